// ==== cachepool_defines.svh ====
// Cluster-wide sizes for the CachePool L2 interconnect
// Address map constants of the DRAM channel regions

`ifndef CACHEPOOL_DEFINES_SVH
`define CACHEPOOL_DEFINES_SVH

// Requester ports, port 0 is the cache bypass
`define NUM_INP 3
// L2 channels, the last one is the default channel
`define NUM_OUT 4

`define ADDR_W 32
`define DATA_W 32

// ------------------------------------------------------------
// Address map
// ------------------------------------------------------------
`define DRAM_BASE    32'h8000_0000
// Must stay a power of two for the NAPOT decode
`define DRAM_CH_SIZE 32'h0100_0000
// Lowest line index bit mixed into the channel select
`define SCR_OFF      6

`define BURST_LEN_W 4

`endif

// ==== cachepool_l2_interconnect.sv ====
// Top level of the CachePool L2 interconnect
// Port decode, request crossbar and response crossbar

`include "cachepool_defines.svh"

module cachepool_l2_interconnect
  import cachepool_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Requester side, port 0 is the cache bypass
  input  l2_req_t [`NUM_INP-1:0]    req_i,
  input  logic    [`NUM_INP-1:0]    req_valid_i,
  output logic    [`NUM_INP-1:0]    req_ready_o,
  output l2_rsp_t [`NUM_INP-1:0]    rsp_o,
  output logic    [`NUM_INP-1:0]    rsp_valid_o,
  input  logic    [`NUM_INP-1:0]    rsp_ready_i,
  // L2 channel side
  output l2_req_t [`NUM_OUT-1:0]    l2_req_o,
  output logic    [`NUM_OUT-1:0]    l2_req_valid_o,
  input  logic    [`NUM_OUT-1:0]    l2_req_ready_i,
  input  l2_rsp_t [`NUM_OUT-1:0]    l2_rsp_i,
  input  logic    [`NUM_OUT-1:0]    l2_rsp_valid_i,
  output logic    [`NUM_OUT-1:0]    l2_rsp_ready_o
);

  logic     [`NUM_INP-1:0][`ADDR_W-1:0] scr_addr;
  out_sel_t [`NUM_INP-1:0]              chan_sel;
  l2_req_t  [`NUM_INP-1:0]              req_stamped;

  // ------------------------------------------------------------
  // Per-port decode and bank_id stamping
  // ------------------------------------------------------------
  for (genvar p = 0; p < `NUM_INP; p++) begin : gen_port
    l2_chan_decode i_decode (
      .addr_i (req_i[p].addr),
      .addr_o (scr_addr[p]  ),
      .sel_o  (chan_sel[p]  )
    );

    // Responses find their way home through bank_id
    always_comb begin : stamp
      req_stamped[p]              = req_i[p];
      req_stamped[p].addr         = scr_addr[p];
      req_stamped[p].user.bank_id = inp_sel_t'(p);
    end
  end

  // ------------------------------------------------------------
  // Crossbars
  // ------------------------------------------------------------
  l2_req_xbar i_req_xbar (
    .clk_i       (clk_i         ),
    .arst_n_i    (arst_n_i      ),
    .inp_req_i   (req_stamped   ),
    .inp_valid_i (req_valid_i   ),
    .inp_sel_i   (chan_sel      ),
    .inp_ready_o (req_ready_o   ),
    .out_req_o   (l2_req_o      ),
    .out_valid_o (l2_req_valid_o),
    .out_ready_i (l2_req_ready_i)
  );

  l2_rsp_xbar i_rsp_xbar (
    .clk_i       (clk_i         ),
    .arst_n_i    (arst_n_i      ),
    .out_rsp_i   (l2_rsp_i      ),
    .out_valid_i (l2_rsp_valid_i),
    .out_ready_o (l2_rsp_ready_o),
    .inp_rsp_o   (rsp_o         ),
    .inp_valid_o (rsp_valid_o   ),
    .inp_ready_i (rsp_ready_i   )
  );

endmodule

// ==== cachepool_pkg.sv ====
// Shared types of the L2 interconnect
// Request, response and user structs, select indices, lock state

`include "cachepool_defines.svh"

package cachepool_pkg;

  // ------------------------------------------------------------
  // Select indices
  // ------------------------------------------------------------
  typedef logic [$clog2(`NUM_INP)-1:0] inp_sel_t;
  typedef logic [$clog2(`NUM_OUT)-1:0] out_sel_t;

  // ------------------------------------------------------------
  // User field
  // ------------------------------------------------------------
  // burst_len counts the beats still to come after this one
  typedef struct packed {
    logic                    is_burst;
    logic [`BURST_LEN_W-1:0] burst_len;
  } burst_t;

  // bank_id names the requester port that issued the request
  typedef struct packed {
    inp_sel_t bank_id;
    burst_t   burst;
  } l2_user_t;

  // ------------------------------------------------------------
  // Request and response payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic                 write;
    logic [`DATA_W-1:0]   data;
    logic [`DATA_W/8-1:0] strb;
    l2_user_t             user;
  } l2_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic               error;
    logic               write;
    l2_user_t           user;
  } l2_rsp_t;

  // Response arbiter state of one requester port
  typedef enum logic {
    RSP_FREE,
    RSP_LOCKED
  } rsp_lock_e;

endpackage

// ==== l2_chan_decode.sv ====
// Address scrambling and NAPOT decode of one requester port
// Picks the DRAM channel or falls back to the default channel

`include "cachepool_defines.svh"

module l2_chan_decode
  import cachepool_pkg::*;
(
  input  logic [`ADDR_W-1:0] addr_i,
  output logic [`ADDR_W-1:0] addr_o,
  output out_sel_t           sel_o
);

  localparam int unsigned AW     = `ADDR_W;
  // Channel select field sits right above the channel region offset
  localparam int unsigned CH_LSB = $clog2(`DRAM_CH_SIZE);
  localparam int unsigned SEL_W  = $clog2(`NUM_OUT - 1);
  localparam logic [`ADDR_W-1:0] CH_MASK = ~(`DRAM_CH_SIZE - 1);

  logic [`ADDR_W-1:0] scr_addr;

  // ------------------------------------------------------------
  // Scrambling
  // ------------------------------------------------------------
  // Line index bits spread consecutive lines over the channels
  always_comb begin : scramble
    scr_addr = addr_i;
    scr_addr[CH_LSB +: SEL_W] = addr_i[CH_LSB +: SEL_W] ^ addr_i[`SCR_OFF +: SEL_W];
  end

  assign addr_o = scr_addr;

  // ------------------------------------------------------------
  // NAPOT decode
  // ------------------------------------------------------------
  always_comb begin : napot_decode
    logic [`ADDR_W-1:0] base;
    sel_o = out_sel_t'(`NUM_OUT - 1);
    for (int i = 0; i < `NUM_OUT - 1; i++) begin
      base = `DRAM_BASE + `DRAM_CH_SIZE * AW'(i);
      if ((scr_addr & CH_MASK) == base) begin
        sel_o = out_sel_t'(i);
      end
    end
  end

endmodule

// ==== l2_req_xbar.sv ====
// Request crossbar from the requester ports to the L2 channels
// Round-robin arbitration and one pipeline register per channel

`include "cachepool_defines.svh"

module l2_req_xbar
  import cachepool_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  l2_req_t  [`NUM_INP-1:0]     inp_req_i,
  input  logic     [`NUM_INP-1:0]     inp_valid_i,
  input  out_sel_t [`NUM_INP-1:0]     inp_sel_i,
  output logic     [`NUM_INP-1:0]     inp_ready_o,
  output l2_req_t  [`NUM_OUT-1:0]     out_req_o,
  output logic     [`NUM_OUT-1:0]     out_valid_o,
  input  logic     [`NUM_OUT-1:0]     out_ready_i
);

  // Port p is accepted by channel c in this cycle
  logic [`NUM_OUT-1:0][`NUM_INP-1:0] port_gnt;

  for (genvar c = 0; c < `NUM_OUT; c++) begin : gen_chan
    logic [`NUM_INP-1:0] chan_req;
    inp_sel_t            arb_idx;
    logic                arb_valid;
    logic                load_en;
    logic                vld_q;
    l2_req_t             req_q;

    for (genvar p = 0; p < `NUM_INP; p++) begin : gen_port
      assign chan_req[p] = inp_valid_i[p] && (inp_sel_i[p] == out_sel_t'(c));
      assign port_gnt[c][p] = arb_valid && load_en && (arb_idx == inp_sel_t'(p));
    end

    // Register takes a new request when empty or draining this cycle
    assign load_en = !vld_q || out_ready_i[c];

    rr_arbiter #(
      .NUM         (`NUM_INP)
    ) i_arb (
      .clk_i       (clk_i    ),
      .arst_n_i    (arst_n_i ),
      .req_i       (chan_req ),
      .lock_i      (1'b0     ),
      .gnt_ready_i (load_en  ),
      .idx_o       (arb_idx  ),
      .valid_o     (arb_valid)
    );

    // ----------------------------------------------------------
    // Pipeline register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        vld_q <= 1'b0;
      end else if (load_en) begin
        vld_q <= arb_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (load_en && arb_valid) begin
        req_q <= inp_req_i[arb_idx];
      end
    end

    assign out_req_o[c]   = req_q;
    assign out_valid_o[c] = vld_q;

    // Stalled channel keeps its request unchanged
    a_stall_stable: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o[c] && !out_ready_i[c] |=> out_valid_o[c] && $stable(out_req_o[c])
    );
  end

  // Each port requests one channel, so at most one grant is set
  always_comb begin : ready_merge
    inp_ready_o = '0;
    for (int c = 0; c < `NUM_OUT; c++) begin
      for (int p = 0; p < `NUM_INP; p++) begin
        inp_ready_o[p] = inp_ready_o[p] | port_gnt[c][p];
      end
    end
  end

endmodule

// ==== l2_rsp_xbar.sv ====
// Response crossbar from the L2 channels back to the requester ports
// Routes by bank_id and keeps a port on one channel for a whole burst

`include "cachepool_defines.svh"

module l2_rsp_xbar
  import cachepool_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  l2_rsp_t [`NUM_OUT-1:0]   out_rsp_i,
  input  logic    [`NUM_OUT-1:0]   out_valid_i,
  output logic    [`NUM_OUT-1:0]   out_ready_o,
  output l2_rsp_t [`NUM_INP-1:0]   inp_rsp_o,
  output logic    [`NUM_INP-1:0]   inp_valid_o,
  input  logic    [`NUM_INP-1:0]   inp_ready_i
);

  // Channel c is consumed by port p in this cycle
  logic [`NUM_INP-1:0][`NUM_OUT-1:0] chan_gnt;

  for (genvar p = 0; p < `NUM_INP; p++) begin : gen_port
    logic [`NUM_OUT-1:0] port_req;
    out_sel_t            arb_idx;
    logic                arb_valid;
    logic                beat_done;
    l2_rsp_t             beat;
    rsp_lock_e           lock_q;
    rsp_lock_e           lock_d;

    for (genvar c = 0; c < `NUM_OUT; c++) begin : gen_chan
      assign port_req[c] = out_valid_i[c] && (out_rsp_i[c].user.bank_id == inp_sel_t'(p));
      assign chan_gnt[p][c] = beat_done && (arb_idx == out_sel_t'(c));
    end

    // The locked channel is the arbiter's last grant
    rr_arbiter #(
      .NUM         (`NUM_OUT)
    ) i_arb (
      .clk_i       (clk_i                 ),
      .arst_n_i    (arst_n_i              ),
      .req_i       (port_req              ),
      .lock_i      (lock_q == RSP_LOCKED  ),
      .gnt_ready_i (inp_ready_i[p]        ),
      .idx_o       (arb_idx               ),
      .valid_o     (arb_valid             )
    );

    assign beat           = out_rsp_i[arb_idx];
    assign beat_done      = arb_valid && inp_ready_i[p];
    assign inp_rsp_o[p]   = beat;
    assign inp_valid_o[p] = arb_valid;

    // ----------------------------------------------------------
    // Burst lock
    // ----------------------------------------------------------
    // Lock on a burst beat with more to come, release on its last beat
    always_comb begin : lock_next
      lock_d = lock_q;
      if (beat_done) begin
        if (beat.user.burst.is_burst && (beat.user.burst.burst_len != '0)) begin
          lock_d = RSP_LOCKED;
        end else begin
          lock_d = RSP_FREE;
        end
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        lock_q <= RSP_FREE;
      end else begin
        lock_q <= lock_d;
      end
    end
  end

  // bank_id picks a single port, so at most one grant per channel
  always_comb begin : ready_merge
    out_ready_o = '0;
    for (int p = 0; p < `NUM_INP; p++) begin
      for (int c = 0; c < `NUM_OUT; c++) begin
        out_ready_o[c] = out_ready_o[c] | chan_gnt[p][c];
      end
    end
  end

  for (genvar c = 0; c < `NUM_OUT; c++) begin : gen_chk
    // A response must name a port that exists
    a_bank_id_range: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      out_valid_i[c] |-> (int'(out_rsp_i[c].user.bank_id) < `NUM_INP)
    );
  end

endmodule

// ==== rr_arbiter.sv ====
// Round-robin arbiter with lock-in
// Serves both the request and the response crossbar

module rr_arbiter #(
  parameter int unsigned NUM = 4,
  localparam int unsigned IDX_W = (NUM > 1) ? $clog2(NUM) : 1
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [NUM-1:0]   req_i,
  input  logic             lock_i,
  input  logic             gnt_ready_i,
  output logic [IDX_W-1:0] idx_o,
  output logic             valid_o
);

  // Search start, one past the last granted index
  logic [IDX_W-1:0] ptr_q;
  // Last granted index, held while locked
  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] rr_idx;
  logic             rr_found;

  // ------------------------------------------------------------
  // Round-robin search
  // ------------------------------------------------------------
  always_comb begin : rr_search
    int j;
    rr_idx   = '0;
    rr_found = 1'b0;
    for (int k = 0; k < NUM; k++) begin
      j = (int'(ptr_q) + k) % NUM;
      if (!rr_found && req_i[j]) begin
        rr_found = 1'b1;
        rr_idx   = IDX_W'(j);
      end
    end
  end

  // A locked arbiter only serves the requester it granted last
  assign idx_o   = lock_i ? last_q : rr_idx;
  assign valid_o = lock_i ? req_i[last_q] : rr_found;

  // ------------------------------------------------------------
  // Pointer update on a completed grant
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q  <= '0;
      last_q <= '0;
    end else if (valid_o && gnt_ready_i) begin
      last_q <= idx_o;
      ptr_q  <= (idx_o == IDX_W'(NUM - 1)) ? '0 : idx_o + 1'b1;
    end
  end

  // A completed grant passes priority on to the other requesters
  a_gnt_rotate: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_o && gnt_ready_i |=> lock_i || ($countones(req_i) < 2) || (idx_o != $past(idx_o))
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the L2 interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_cachepool_l2_interconnect -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST PASSED" sim.log

// ==== tb_cachepool_l2_interconnect.sv ====
// Testbench of the CachePool L2 interconnect
// L2 channel models, reference decode, checker and watchdog

`include "cachepool_defines.svh"

module tb_cachepool_l2_interconnect
  import cachepool_pkg::*;
;

  localparam int N_REQ     = 40;
  localparam int CYC_BOUND = 40;
  localparam longint TIMEOUT = longint'(N_REQ) * `NUM_INP * CYC_BOUND * 100;
  localparam int CH_SHIFT  = $clog2(`DRAM_CH_SIZE);
  localparam int SEL_BITS  = $clog2(`NUM_OUT - 1);
  localparam logic [31:0] DIR_ADDR [4] = '{32'h8000_0004, 32'h8100_0004,
                                          32'h0000_1000, 32'hC000_0008};

  typedef struct packed {
    out_sel_t           chan;
    logic [`ADDR_W-1:0] addr;
  } route_t;

  logic clk;
  logic arst_n;
  logic run_stim;
  l2_req_t [`NUM_INP-1:0] req_i;
  logic    [`NUM_INP-1:0] req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
  l2_rsp_t [`NUM_INP-1:0] rsp_o;
  l2_req_t [`NUM_OUT-1:0] l2_req_o;
  logic    [`NUM_OUT-1:0] l2_req_valid_o, l2_req_ready_i, l2_rsp_valid_i, l2_rsp_ready_o;
  l2_rsp_t [`NUM_OUT-1:0] l2_rsp_i;

  logic [31:0] rng_state = 32'd62;
  int issued [`NUM_INP];
  int owed [`NUM_INP];
  int recv [`NUM_INP];
  logic [`NUM_INP-1:0] lock_act = '0;
  out_sel_t lock_ch [`NUM_INP];
  logic [`NUM_OUT-1:0] stall_q = '0;
  l2_req_t held [`NUM_OUT];
  int overlap_seen = 0;
  // Expected traffic per channel, and the response beats each channel model still has to send
  l2_req_t req_exp [`NUM_OUT][$];
  l2_rsp_t rsp_exp [`NUM_OUT][$];
  l2_rsp_t mq [`NUM_OUT][$];

  cachepool_l2_interconnect DUT (.clk_i(clk), .arst_n_i(arst_n), .*);

  always #50 clk = ~clk;

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic coin(input int pct);
    logic [31:0] v;
    v = rand32();
    return (v[30:16] % 100) < pct;
  endfunction

  // Expected scrambled address and channel of one request
  function automatic route_t ref_route(input logic [`ADDR_W-1:0] a);
    route_t r;
    logic [`ADDR_W-1:0] mix;
    logic [`ADDR_W-1:0] off;
    mix    = (a >> `SCR_OFF) & ((32'd1 << SEL_BITS) - 1);
    r.addr = a ^ (mix << CH_SHIFT);
    off    = r.addr - `DRAM_BASE;
    if (r.addr >= `DRAM_BASE && (off >> CH_SHIFT) < `NUM_OUT - 1) begin
      r.chan = out_sel_t'(off >> CH_SHIFT);
    end else begin
      r.chan = out_sel_t'(`NUM_OUT - 1);
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string name, input logic [79:0] got, input logic [79:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  function automatic logic traffic_done();
    logic d;
    d = (req_valid_i == '0) && (l2_req_valid_o == '0) && (l2_rsp_valid_i == '0);
    for (int p = 0; p < `NUM_INP; p++) d = d && (issued[p] == N_REQ);
    for (int c = 0; c < `NUM_OUT; c++) begin
      d = d && (req_exp[c].size() == 0) && (rsp_exp[c].size() == 0) && (mq[c].size() == 0);
    end
    return d;
  endfunction

  // ------------------------------------------------------------
  // Stimulus and L2 channel models
  // ------------------------------------------------------------
  always @(posedge clk) begin : drive
    l2_req_t nreq;
    l2_rsp_t beat;
    logic [31:0] r;
    int nbeat;
    if (arst_n && run_stim) begin
      for (int c = 0; c < `NUM_OUT; c++) begin
        if (l2_rsp_valid_i[c] && l2_rsp_ready_o[c]) void'(mq[c].pop_front());
        if (l2_req_valid_o[c] && l2_req_ready_i[c]) begin
          // Bit 2 of the address asks for a four beat burst
          nbeat = l2_req_o[c].addr[2] ? 4 : 1;
          for (int b = 0; b < nbeat; b++) begin
            beat = '0;
            beat.data = l2_req_o[c].addr ^ `DATA_W'(c);
            // Bit 3 marks an error response
            beat.error = l2_req_o[c].addr[3];
            beat.write = l2_req_o[c].write;
            beat.user.bank_id = l2_req_o[c].user.bank_id;
            beat.user.burst.is_burst = (nbeat > 1);
            beat.user.burst.burst_len = `BURST_LEN_W'(nbeat - 1 - b);
            mq[c].push_back(beat);
          end
        end
        l2_rsp_valid_i[c] <= (mq[c].size() != 0);
        if (mq[c].size() != 0) l2_rsp_i[c] <= mq[c][0];
        l2_req_ready_i[c] <= coin(70);
      end
      for (int p = 0; p < `NUM_INP; p++) begin
        if (!(req_valid_i[p] && !req_ready_o[p])) begin
          if (issued[p] < N_REQ && coin(60)) begin
            nreq = '0;
            r = rand32();
            case (r[18:16] % 5)
              0, 1, 2: nreq.addr = `DRAM_BASE | (rand32() & 32'h03FF_FFFF);
              3:       nreq.addr = rand32() & 32'h7FFF_FFFF;
              default: nreq.addr = rand32() | 32'h8400_0000;
            endcase
            // Port 0 opens with two bursts on channels 0 and 1, then two default hits
            if (p == 0 && issued[0] < 4) nreq.addr = DIR_ADDR[issued[0]];
            r = rand32();
            nreq.write = r[20];
            nreq.strb = r[`DATA_W/8-1:0];
            nreq.user.bank_id = inp_sel_t'(r[9:8]);
            nreq.data = rand32();
            req_i[p] <= nreq;
            req_valid_i[p] <= 1'b1;
            issued[p]++;
          end else begin
            req_valid_i[p] <= 1'b0;
          end
        end
        rsp_ready_i[p] <= coin(70);
      end
    end
  end

  // ------------------------------------------------------------
  // Checker, sampled where the next edge's handshakes are settled
  // ------------------------------------------------------------
  always @(negedge clk) begin : check_proc
    l2_req_t e_req;
    l2_rsp_t e_rsp;
    route_t rt;
    logic [`NUM_INP-1:0] port_hs;
    logic [`NUM_OUT-1:0] chan_hs;
    int src;
    int nsrc;
    int bank;
    if (arst_n) begin
      for (int c = 0; c < `NUM_OUT; c++) begin
        if (stall_q[c]) begin
          compare($sformatf("l2_req_valid_o[%0d]", c), l2_req_valid_o[c], 1'b1);
          compare($sformatf("l2_req_o[%0d]", c), l2_req_o[c], held[c]);
        end
        stall_q[c] = l2_req_valid_o[c] && !l2_req_ready_i[c];
        held[c] = l2_req_o[c];
        if (l2_req_valid_o[c] && l2_req_ready_i[c]) begin
          if (req_exp[c].size() == 0) abort_run($sformatf("unexpected request on channel %0d", c));
          e_req = req_exp[c].pop_front();
          compare($sformatf("l2_req_o[%0d].addr", c), l2_req_o[c].addr, e_req.addr);
          compare($sformatf("l2_req_o[%0d].write", c), l2_req_o[c].write, e_req.write);
          compare($sformatf("l2_req_o[%0d].data", c), l2_req_o[c].data, e_req.data);
          compare($sformatf("l2_req_o[%0d].strb", c), l2_req_o[c].strb, e_req.strb);
          compare($sformatf("l2_req_o[%0d].bank_id", c), l2_req_o[c].user.bank_id,
                  e_req.user.bank_id);
          for (int b = 0; b < (e_req.addr[2] ? 4 : 1); b++) begin
            e_rsp = '0;
            e_rsp.data = e_req.addr ^ `DATA_W'(c);
            e_rsp.error = e_req.addr[3];
            e_rsp.write = e_req.write;
            e_rsp.user.bank_id = e_req.user.bank_id;
            e_rsp.user.burst.is_burst = e_req.addr[2];
            e_rsp.user.burst.burst_len = e_req.addr[2] ? `BURST_LEN_W'(3 - b) : '0;
            rsp_exp[c].push_back(e_rsp);
            owed[e_req.user.bank_id]++;
          end
        end
      end
      for (int p = 0; p < `NUM_INP; p++) begin
        if (req_valid_i[p] && req_ready_o[p]) begin
          rt = ref_route(req_i[p].addr);
          e_req = req_i[p];
          e_req.addr = rt.addr;
          e_req.user.bank_id = inp_sel_t'(p);
          req_exp[rt.chan].push_back(e_req);
        end
      end
      port_hs = rsp_valid_o & rsp_ready_i;
      chan_hs = l2_rsp_valid_i & l2_rsp_ready_o;
      for (int c = 0; c < `NUM_OUT; c++) begin
        bank = int'(l2_rsp_i[c].user.bank_id);
        if (chan_hs[c] && !port_hs[bank]) begin
          abort_run($sformatf("channel %0d response taken but port %0d got nothing", c, bank));
        end
      end
      for (int p = 0; p < `NUM_INP; p++) begin
        if (lock_act[p]) begin
          for (int c = 0; c < `NUM_OUT; c++) begin
            if (c != int'(lock_ch[p]) && l2_rsp_valid_i[c] &&
                l2_rsp_i[c].user.bank_id == inp_sel_t'(p)) overlap_seen++;
          end
        end
        if (port_hs[p]) begin
          nsrc = 0;
          src = 0;
          for (int c = 0; c < `NUM_OUT; c++) begin
            if (chan_hs[c] && l2_rsp_i[c].user.bank_id == inp_sel_t'(p)) begin
              nsrc++;
              src = c;
            end
          end
          compare($sformatf("rsp source count of port %0d", p), nsrc, 1);
          if (rsp_exp[src].size() == 0) abort_run($sformatf("unowed response on channel %0d", src));
          e_rsp = rsp_exp[src].pop_front();
          compare($sformatf("rsp_o[%0d].data", p), rsp_o[p].data, e_rsp.data);
          compare($sformatf("rsp_o[%0d].error", p), rsp_o[p].error, e_rsp.error);
          compare($sformatf("rsp_o[%0d].write", p), rsp_o[p].write, e_rsp.write);
          compare($sformatf("rsp_o[%0d].user", p), rsp_o[p].user, e_rsp.user);
          if (lock_act[p]) compare($sformatf("burst channel of port %0d", p), src, lock_ch[p]);
          lock_act[p] = e_rsp.user.burst.is_burst && (e_rsp.user.burst.burst_len != '0);
          lock_ch[p] = out_sel_t'(src);
          recv[p]++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    abort_run("timeout, traffic did not drain in time");
  end

  initial begin : main
    clk = 1'b0;
    arst_n = 1'b0;
    run_stim = 1'b0;
    req_i = '0;
    req_valid_i = '0;
    rsp_ready_i = '0;
    l2_req_ready_i = '0;
    l2_rsp_i = '0;
    l2_rsp_valid_i = '0;
    for (int p = 0; p < `NUM_INP; p++) begin
      issued[p] = 0;
      owed[p] = 0;
      recv[p] = 0;
    end
    @(posedge clk);
    @(negedge clk);
    compare("l2_req_valid_o", l2_req_valid_o, '0);
    compare("rsp_valid_o", rsp_valid_o, '0);
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare("l2_req_valid_o", l2_req_valid_o, '0);
    compare("rsp_valid_o", rsp_valid_o, '0);
    @(posedge clk);
    run_stim <= 1'b1;
    do begin
      @(posedge clk);
      #10;
    end while (!traffic_done());
    for (int p = 0; p < `NUM_INP; p++) compare($sformatf("beats of port %0d", p), recv[p], owed[p]);
    compare("burst overlap seen", overlap_seen > 0, 1'b1);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
cachepool_pkg.sv
rr_arbiter.sv
l2_chan_decode.sv
l2_req_xbar.sv
l2_rsp_xbar.sv
cachepool_l2_interconnect.sv
tb_cachepool_l2_interconnect.sv
